// File: design/cpu_types_pkg.sv
package cpu_types_pkg;

    typedef logic [31:0] word_t;    // One data word
    typedef logic [63:0] dword_t;   // Full product or HI:LO pair

    // Write request toward HI/LO, one enable per half
    typedef struct packed {
        logic  hi_we;               // Write HI
        logic  lo_we;               // Write LO
        word_t hi;                  // New HI value
        word_t lo;                  // New LO value
    } hilo_wr_t;

endpackage

// File: design/muldiv_pkg.sv
package muldiv_pkg;

    // Execute-stage HI/LO operations
    typedef enum logic [2:0] {
        op_mthi  = 3'd0,            // HI <- rs
        op_mtlo  = 3'd1,            // LO <- rs
        op_mult  = 3'd2,            // Signed product
        op_multu = 3'd3,            // Unsigned product
        op_div   = 3'd4,            // Signed divide
        op_divu  = 3'd5             // Unsigned divide
    } hilo_op_t;

    // Iterative divider control
    typedef enum logic [1:0] {
        div_idle = 2'd0,            // Waiting for start
        div_run  = 2'd1,            // Shift-subtract steps
        div_done = 2'd2             // Result valid, one cycle
    } div_state_t;

endpackage

// File: design/div_fsm.sv
`timescale 1ns/1ps

module div_fsm (
    input  logic clk,
    input  logic rst_n_i,
    input  logic start_i,           // Divide accepted last cycle
    input  logic cnt_last_i,        // Final iteration running
    output logic cnt_clr_o,
    output logic cnt_en_o,
    output logic dp_load_o,
    output logic dp_step_o,
    output logic busy_o,
    output logic done_o
);

    muldiv_pkg::div_state_t state_q;
    muldiv_pkg::div_state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            muldiv_pkg::div_idle: if (start_i) state_d = muldiv_pkg::div_run;
            muldiv_pkg::div_run:  if (cnt_last_i) state_d = muldiv_pkg::div_done;
            muldiv_pkg::div_done: state_d = muldiv_pkg::div_idle; // Single cycle
            default:              state_d = muldiv_pkg::div_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= muldiv_pkg::div_idle;
        end else begin
            state_q <= state_d;
        end
    end

    assign dp_load_o = (state_q == muldiv_pkg::div_idle) && start_i; // Latch operands
    assign cnt_clr_o = (state_q == muldiv_pkg::div_idle) && start_i;
    assign dp_step_o = (state_q == muldiv_pkg::div_run);
    assign cnt_en_o  = (state_q == muldiv_pkg::div_run) && !cnt_last_i; // Hold at last
    assign done_o    = (state_q == muldiv_pkg::div_done);
    // Busy covers the start cycle too, so no new strobe sneaks in
    assign busy_o    = start_i || (state_q != muldiv_pkg::div_idle);

    // Busy drops together with the done pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        done_o |=> (!done_o && !busy_o))
        else $error("done_o or busy_o still high after the done cycle");

    // Execute stage must respect busy before starting a divide
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        start_i |-> state_q == muldiv_pkg::div_idle)
        else $error("divide started while divider busy");

endmodule

// File: design/div_counter.sv
`timescale 1ns/1ps

module div_counter #(
    parameter int DIV_ITER = 32     // Iterations per divide
) (
    input  logic clk,
    input  logic rst_n_i,
    input  logic cnt_clr_i,         // Restart at zero
    input  logic cnt_en_i,          // Advance one step
    output logic cnt_last_o         // Final iteration
);

    // One spare code above the last count so an overrun is visible
    localparam int CNT_W = $clog2(DIV_ITER + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(DIV_ITER - 1);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i || cnt_clr_i) begin
            cnt_q <= '0;
        end else if (cnt_en_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign cnt_last_o = (cnt_q == LAST);

    // FSM must stop enabling once the last step is flagged
    a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n_i)
        cnt_q <= LAST)
        else $error("divider count past last iteration");

endmodule

// File: design/div_datapath.sv
`timescale 1ns/1ps

module div_datapath #(
    parameter int DIV_ITER = 32     // Bits of quotient, one per step
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 load_i,        // Capture operands
    input  logic                 step_i,        // One shift-subtract
    input  logic                 signed_i,      // Two's complement operands
    input  cpu_types_pkg::word_t dividend_i,
    input  cpu_types_pkg::word_t divisor_i,
    output cpu_types_pkg::word_t quot_o,
    output cpu_types_pkg::word_t rem_o
);

    logic [DIV_ITER-1:0] quo_q;     // Dividend bits shift out, quotient bits in
    logic [DIV_ITER-1:0] dvs_q;     // Divisor magnitude
    logic [DIV_ITER-1:0] rem_q;     // Partial remainder
    logic                q_neg_q;   // Negate quotient at output
    logic                r_neg_q;   // Remainder follows dividend sign
    logic                a_neg;
    logic                b_neg;
    logic [DIV_ITER-1:0] a_mag;
    logic [DIV_ITER-1:0] b_mag;
    logic [DIV_ITER:0]   rem_sh;
    logic [DIV_ITER:0]   trial;

    assign a_neg  = signed_i & dividend_i[DIV_ITER-1];
    assign b_neg  = signed_i & divisor_i[DIV_ITER-1];
    assign a_mag  = a_neg ? -dividend_i[DIV_ITER-1:0] : dividend_i[DIV_ITER-1:0];
    assign b_mag  = b_neg ? -divisor_i[DIV_ITER-1:0] : divisor_i[DIV_ITER-1:0];

    assign rem_sh = {rem_q, quo_q[DIV_ITER-1]};    // Bring down next bit
    assign trial  = rem_sh - {1'b0, dvs_q};        // MSB set means borrow

    always_ff @(posedge clk) begin
        if (load_i) begin
            quo_q <= a_mag;
            dvs_q <= b_mag;
            rem_q <= '0;
        end else if (step_i) begin
            quo_q <= {quo_q[DIV_ITER-2:0], ~trial[DIV_ITER]};
            rem_q <= trial[DIV_ITER] ? rem_sh[DIV_ITER-1:0] : trial[DIV_ITER-1:0]; // Restore
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            q_neg_q <= 1'b0;
            r_neg_q <= 1'b0;
        end else if (load_i) begin
            q_neg_q <= a_neg ^ b_neg;
            r_neg_q <= a_neg;
        end
    end

    // Quotient truncates toward zero and a zero divisor yields all ones
    assign quot_o = q_neg_q ? -quo_q : quo_q;
    assign rem_o  = r_neg_q ? -rem_q : rem_q;

endmodule

// File: design/muldiv_ex.sv
`timescale 1ns/1ps

module muldiv_ex (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   ex_valid_i,   // Instruction strobe
    input  muldiv_pkg::hilo_op_t   ex_op_i,
    input  cpu_types_pkg::word_t   rs_i,
    input  cpu_types_pkg::word_t   rt_i,
    input  logic                   busy_i,       // Divider occupied
    input  logic                   div_done_i,   // Divider result valid
    input  cpu_types_pkg::word_t   quot_i,
    input  cpu_types_pkg::word_t   rem_i,
    output logic                   div_start_o,
    output logic                   div_signed_o,
    output cpu_types_pkg::word_t   div_a_o,
    output cpu_types_pkg::word_t   div_b_o,
    output cpu_types_pkg::hilo_wr_t ex_wr_o
);

    localparam int W = $bits(cpu_types_pkg::word_t);

    logic                  accept;   // Strobe taken this cycle
    logic                  is_div;
    logic                  sext;     // Sign-extend multiplier operands
    cpu_types_pkg::dword_t mul_a;
    cpu_types_pkg::dword_t mul_b;
    cpu_types_pkg::dword_t prod;

    assign accept = ex_valid_i && !busy_i;    // Strobes dropped while busy
    assign is_div = (ex_op_i == muldiv_pkg::op_div) || (ex_op_i == muldiv_pkg::op_divu);
    assign sext   = (ex_op_i == muldiv_pkg::op_mult);

    // Low 64 bits of the extended product are right for both signs
    assign mul_a = {{W{sext & rs_i[W-1]}}, rs_i};
    assign mul_b = {{W{sext & rt_i[W-1]}}, rt_i};
    assign prod  = mul_a * mul_b;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            div_start_o <= 1'b0;
        end else begin
            div_start_o <= accept && is_div;  // One-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (accept && is_div) begin
            div_a_o      <= rs_i;
            div_b_o      <= rt_i;
            div_signed_o <= (ex_op_i == muldiv_pkg::op_div);
        end
    end

    always_comb begin
        ex_wr_o = '0;
        if (div_done_i) begin                 // Strobes blocked while busy
            ex_wr_o = '{hi_we: 1'b1, lo_we: 1'b1, hi: rem_i, lo: quot_i};
        end else if (accept) begin
            case (ex_op_i)
                muldiv_pkg::op_mthi: ex_wr_o = '{hi_we: 1'b1, lo_we: 1'b0, hi: rs_i, lo: '0};
                muldiv_pkg::op_mtlo: ex_wr_o = '{hi_we: 1'b0, lo_we: 1'b1, hi: '0, lo: rs_i};
                muldiv_pkg::op_mult,
                muldiv_pkg::op_multu:
                    ex_wr_o = '{hi_we: 1'b1, lo_we: 1'b1, hi: prod[2*W-1:W], lo: prod[W-1:0]};
                default: ex_wr_o = '0;        // Divides write later
            endcase
        end
    end

endmodule

// File: design/hilo_pipe.sv
`timescale 1ns/1ps

module hilo_pipe (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  cpu_types_pkg::hilo_wr_t ex_wr_i,    // From execute
    output cpu_types_pkg::hilo_wr_t mem_wr_o,   // MEM stage
    output cpu_types_pkg::hilo_wr_t wb_wr_o     // WB stage
);

    cpu_types_pkg::hilo_wr_t mem_q;
    cpu_types_pkg::hilo_wr_t wb_q;

    always_ff @(posedge clk) begin
        mem_q <= ex_wr_i;
        wb_q  <= mem_q;
        if (!rst_n_i) begin                     // Drop pending writes
            mem_q.hi_we <= 1'b0;
            mem_q.lo_we <= 1'b0;
            wb_q.hi_we  <= 1'b0;
            wb_q.lo_we  <= 1'b0;
        end
    end

    assign mem_wr_o = mem_q;
    assign wb_wr_o  = wb_q;

endmodule

// File: design/hilo_regs.sv
`timescale 1ns/1ps

module hilo_regs (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  cpu_types_pkg::hilo_wr_t mem_wr_i,   // Youngest pending write
    input  cpu_types_pkg::hilo_wr_t wb_wr_i,    // Committing this cycle
    output cpu_types_pkg::word_t    hi_o,
    output cpu_types_pkg::word_t    lo_o
);

    cpu_types_pkg::word_t hi_q;   // Architectural HI
    cpu_types_pkg::word_t lo_q;   // Architectural LO

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            if (wb_wr_i.hi_we) begin
                hi_q <= wb_wr_i.hi;
            end
            if (wb_wr_i.lo_we) begin
                lo_q <= wb_wr_i.lo;
            end
        end
    end

    // Reader in execute is younger than both stages, so MEM beats WB
    always_comb begin
        if (mem_wr_i.hi_we) begin
            hi_o = mem_wr_i.hi;
        end else if (wb_wr_i.hi_we) begin
            hi_o = wb_wr_i.hi;        // Not yet in hi_q
        end else begin
            hi_o = hi_q;
        end
    end

    always_comb begin
        if (mem_wr_i.lo_we) begin
            lo_o = mem_wr_i.lo;
        end else if (wb_wr_i.lo_we) begin
            lo_o = wb_wr_i.lo;
        end else begin
            lo_o = lo_q;
        end
    end

endmodule

// File: design/hilo_unit.sv
`timescale 1ns/1ps

module hilo_unit #(
    parameter int DIV_ITER = 32     // Matches word width
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 ex_valid_i,
    input  muldiv_pkg::hilo_op_t ex_op_i,
    input  cpu_types_pkg::word_t rs_i,
    input  cpu_types_pkg::word_t rt_i,
    output cpu_types_pkg::word_t hi_o,
    output cpu_types_pkg::word_t lo_o,
    output logic                 busy_o,
    output logic                 done_o
);

    cpu_types_pkg::hilo_wr_t ex_wr;
    cpu_types_pkg::hilo_wr_t mem_wr;
    cpu_types_pkg::hilo_wr_t wb_wr;
    cpu_types_pkg::word_t    div_a;
    cpu_types_pkg::word_t    div_b;
    cpu_types_pkg::word_t    quot;
    cpu_types_pkg::word_t    rem;
    logic div_start;
    logic div_signed;
    logic cnt_clr;
    logic cnt_en;
    logic cnt_last;
    logic dp_load;
    logic dp_step;

    muldiv_ex u_ex (
        .clk, .rst_n_i, .ex_valid_i, .ex_op_i, .rs_i, .rt_i,
        .busy_i(busy_o), .div_done_i(done_o), .quot_i(quot), .rem_i(rem),
        .div_start_o(div_start), .div_signed_o(div_signed),
        .div_a_o(div_a), .div_b_o(div_b), .ex_wr_o(ex_wr)
    );

    div_fsm u_fsm (
        .clk, .rst_n_i, .start_i(div_start), .cnt_last_i(cnt_last),
        .cnt_clr_o(cnt_clr), .cnt_en_o(cnt_en), .dp_load_o(dp_load),
        .dp_step_o(dp_step), .busy_o, .done_o
    );

    div_counter #(.DIV_ITER(DIV_ITER)) u_cnt (
        .clk, .rst_n_i, .cnt_clr_i(cnt_clr), .cnt_en_i(cnt_en), .cnt_last_o(cnt_last)
    );

    div_datapath #(.DIV_ITER(DIV_ITER)) u_dp (
        .clk, .rst_n_i, .load_i(dp_load), .step_i(dp_step), .signed_i(div_signed),
        .dividend_i(div_a), .divisor_i(div_b), .quot_o(quot), .rem_o(rem)
    );

    hilo_pipe u_pipe (
        .clk, .rst_n_i, .ex_wr_i(ex_wr), .mem_wr_o(mem_wr), .wb_wr_o(wb_wr)
    );

    hilo_regs u_regs (
        .clk, .rst_n_i, .mem_wr_i(mem_wr), .wb_wr_i(wb_wr), .hi_o, .lo_o
    );

endmodule

// File: sim/tb_hilo_unit.sv
`timescale 1ns/1ps

module tb_hilo_unit;

    localparam int DIV_ITER = 32;
    localparam int N_OPS    = 24;           // Moves, multiplies and divides issued
    localparam int LIMIT    = 60 * N_OPS;   // Cycle budget for the whole run

    logic                 clk;
    logic                 rst_n;
    logic                 ex_valid;
    muldiv_pkg::hilo_op_t ex_op;
    cpu_types_pkg::word_t rs;
    cpu_types_pkg::word_t rt;
    cpu_types_pkg::word_t hi_o;
    cpu_types_pkg::word_t lo_o;
    logic                 busy;
    logic                 done;
    cpu_types_pkg::word_t exp_hi;           // Model of HI as seen by a reader
    cpu_types_pkg::word_t exp_lo;
    logic                 div_pend;         // Divide in flight
    int                   done_due;         // Cycle count when done_o is due
    int                   cyc = 0;
    int                   err_cnt = 0;
    int                   test_cnt = 0;
    int                   fail_cnt = 0;
    int                   mark;
    logic [31:0]          rng;

    hilo_unit #(.DIV_ITER(DIV_ITER)) dut (
        .clk, .rst_n_i(rst_n), .ex_valid_i(ex_valid), .ex_op_i(ex_op), .rs_i(rs),
        .rt_i(rt), .hi_o, .lo_o, .busy_o(busy), .done_o(done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    initial begin : watchdog
        repeat (LIMIT) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", LIMIT);
        $display("** FAIL **");
        $finish;
    end

    task automatic log_error(input string msg);
        err_cnt++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    a_hilo: assert property (@(posedge clk) disable iff (!rst_n)
        (hi_o == exp_hi && lo_o == exp_lo))
        else log_error($sformatf("HI/LO %h %h, expected %h %h", $sampled(hi_o),
                                 $sampled(lo_o), $sampled(exp_hi), $sampled(exp_lo)));
    a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !div_pend |-> (!busy && !done))
        else log_error("busy_o or done_o high with no divide pending");
    a_busy: assert property (@(posedge clk) disable iff (!rst_n) div_pend |-> busy)
        else log_error("busy_o low during a divide");
    a_done_at: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (div_pend && cyc == done_due))
        else log_error($sformatf("done_o at cycle %0d, due %0d", $sampled(cyc), done_due));
    a_done_due: assert property (@(posedge clk) disable iff (!rst_n)
        (div_pend && cyc == done_due) |-> done)
        else log_error("done_o missing at its due cycle");

    function automatic cpu_types_pkg::word_t rand_word();
        rng = rng ^ (rng << 13);                // xorshift32
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic cpu_types_pkg::dword_t mul_ref(input logic sgn,
            input cpu_types_pkg::word_t a, input cpu_types_pkg::word_t b);
        longint sa;
        longint sb;
        sa = sgn ? longint'($signed(a)) : longint'({32'd0, a});
        sb = sgn ? longint'($signed(b)) : longint'({32'd0, b});
        return cpu_types_pkg::dword_t'(sa * sb);    // Low 64 bits are exact either way
    endfunction

    // Truncating divide on magnitudes with an all-ones quotient for a zero divisor
    function automatic void div_ref(input logic sgn, input cpu_types_pkg::word_t a,
            input cpu_types_pkg::word_t b, output cpu_types_pkg::word_t q,
            output cpu_types_pkg::word_t r);
        logic an;
        logic bn;
        cpu_types_pkg::word_t am;
        cpu_types_pkg::word_t bm;
        an = sgn & a[31];
        bn = sgn & b[31];
        am = an ? -a : a;
        bm = bn ? -b : b;
        q  = (bm == 0) ? '1 : am / bm;
        r  = (bm == 0) ? am : am % bm;
        q  = (an ^ bn) ? -q : q;
        r  = an ? -r : r;                       // Remainder follows dividend
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic issue(input muldiv_pkg::hilo_op_t op, input cpu_types_pkg::word_t a,
                         input cpu_types_pkg::word_t b);
        cpu_types_pkg::dword_t p;
        ex_valid = 1'b1;
        ex_op    = op;
        rs       = a;
        rt       = b;
        @(posedge clk);
        #1;
        ex_valid = 1'b0;
        p = mul_ref(op == muldiv_pkg::op_mult, a, b);
        if (op == muldiv_pkg::op_mthi) exp_hi = a;
        else if (op == muldiv_pkg::op_mtlo) exp_lo = a;
        else {exp_hi, exp_lo} = p;
    endtask

    task automatic run_div(input logic sgn, input cpu_types_pkg::word_t a,
                           input cpu_types_pkg::word_t b);
        cpu_types_pkg::word_t q;
        cpu_types_pkg::word_t r;
        div_ref(sgn, a, b, q, r);
        ex_valid = 1'b1;
        if (sgn) ex_op = muldiv_pkg::op_div;
        else ex_op = muldiv_pkg::op_divu;
        rs = a;
        rt = b;
        @(posedge clk);
        #1;
        div_pend = 1'b1;
        done_due = cyc + DIV_ITER + 1;
        while (!done) begin
            ex_valid = 1'b1;                    // Stray strobe dropped while busy
            ex_op    = muldiv_pkg::hilo_op_t'(3'(rand_word() % 6));
            rs       = rand_word();
            rt       = rand_word();
            idle(1);
        end
        ex_valid = 1'b0;
        idle(1);                                // Result forwarded from MEM now
        div_pend = 1'b0;
        exp_hi   = r;
        exp_lo   = q;
    endtask

    task automatic close_test(input string name, input int err_before);
        idle(3);
        test_cnt++;
        if (err_cnt == err_before) begin
            $display("test %s passed", name);
        end else begin
            fail_cnt++;
            $display("test %s failed with %0d errors", name, err_cnt - err_before);
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        ex_valid = 1'b0;
        ex_op    = muldiv_pkg::op_mthi;
        rs       = '0;
        rt       = '0;
        exp_hi   = '0;
        exp_lo   = '0;
        div_pend = 1'b0;
        done_due = 0;
        rng      = 67;
        repeat (3) @(posedge clk);
        #1;
        rst_n  = 1'b1;
        mark = err_cnt;
        close_test("reset", mark);
        mark = err_cnt;
        issue(muldiv_pkg::op_mthi, rand_word(), '0);
        idle(2);
        issue(muldiv_pkg::op_mtlo, rand_word(), '0);
        idle(2);
        issue(muldiv_pkg::op_mthi, rand_word(), '0);
        issue(muldiv_pkg::op_mtlo, rand_word(), '0);
        close_test("move", mark);
        mark = err_cnt;
        issue(muldiv_pkg::op_mtlo, rand_word(), '0);
        issue(muldiv_pkg::op_mtlo, rand_word(), '0);   // Younger value must win
        close_test("forward", mark);
        mark = err_cnt;
        for (int i = 0; i < 8; i++) begin
            if (i % 2 == 0) issue(muldiv_pkg::op_mult, rand_word(), rand_word());
            else issue(muldiv_pkg::op_multu, rand_word(), rand_word());
        end
        close_test("mult", mark);
        mark = err_cnt;
        for (int i = 0; i < 8; i++) begin
            run_div(i % 2 == 0, rand_word(), rand_word() >> (rand_word() % 24));
        end
        close_test("div", mark);
        mark = err_cnt;
        run_div(1'b0, rand_word(), '0);
        run_div(1'b1, 32'h1234_5678, '0);
        close_test("div_zero", mark);
        $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) $display("** PASS **");
        else $display("** FAIL **");
        $finish;
    end

endmodule

// File: hilo_unit.f
design/cpu_types_pkg.sv
design/muldiv_pkg.sv
design/div_fsm.sv
design/div_counter.sv
design/div_datapath.sv
design/muldiv_ex.sv
design/hilo_pipe.sv
design/hilo_regs.sv
design/hilo_unit.sv
sim/tb_hilo_unit.sv

// File: Makefile
TOP := tb_hilo_unit

.PHONY: all build lint clean

all: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f hilo_unit.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f hilo_unit.f

clean:
	rm -rf obj_dir sim.log
